// File: Bender.yml
package:
  name: mm_ram

sources:
  - include_dirs:
      - src
    files:
      - src/mm_ram_pkg.sv
      - src/mm_addr_decode.sv
      - src/data_bus_ctrl.sv
      - src/dp_ram.sv
      - src/sim_periph.sv
      - src/debug_req_gen.sv
      - src/mm_ram_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/mm_ram_chk.sv
      - sim/mm_ram_tb.sv

// File: list.f
+incdir+src
src/mm_ram_pkg.sv
src/mm_addr_decode.sv
src/data_bus_ctrl.sv
src/dp_ram.sv
src/sim_periph.sv
src/debug_req_gen.sv
src/mm_ram_top.sv
sim/mm_ram_chk.sv
sim/mm_ram_tb.sv

// File: sim/mm_ram_cases.txt
# columns: op name addr data expected, all numbers in hex
# W: expected = byte enables, R: read word, F: 128-bit line, S: flags {exit,fail,pass}
# T: addr = mask, data = count, expected = cycles to irq (0 = none), D: expected = {L,D}
W w_full        00000000 11223344 f
W w_be_lo       00000000 aabbccdd 3
R r_merge_lo    00000000 00000000 1122ccdd
W w_be_hi       00000000 55667788 c
W w_word1       00000004 deadbeef f
W w_be_mid      00000004 00a5a500 6
W w_be_none     00000004 ffffffff 0
R r_merge_hi    00000000 00000000 5566ccdd
R r_merge_mid   00000004 00000000 dea5a5ef
W w_line0       00000100 03020100 f
W w_line1       00000104 07060504 f
W w_line2       00000108 0b0a0908 f
W w_line3       0000010c 0f0e0d0c f
F f_line        0000010c 00000000 0f0e0d0c0b0a09080706050403020100
R r_unmapped    30000000 00000000 badc0de0
R r_status_rd   20000000 00000000 badc0de0
S s_pass        20000000 075bcd15 1
S s_fail        20000000 00000001 2
S s_other       20000000 00000005 0
S s_exit        20000004 0000002a 4
T t_irq5        00000008 00000005 5
T t_irq1        00000008 00000001 1
T t_masked      00000000 00000004 0
T t_irq12       ffffffff 0000000c c
D d_level1      00000000 80000003 00000003
D d_level0_zero 00000000 00000000 00000001
D d_pulse       00000000 c0050004 00050004
D d_pulse_zero  00000000 c0000000 00010001
D d_rsvd_bits   00000000 a0008002 00000002
D d_pulse_low   00000000 40020003 00020003

// File: sim/mm_ram_chk.sv
// bus handshake and interrupt rules for the memory block
// bound into the top level

`include "mm_ram_cfg.svh"

module mm_ram_chk
    import mm_ram_pkg::*;
(
    input logic                        clk_i,
    input logic                        rst_ni,
    input logic                        instr_req_i,
    input logic                        instr_gnt_o,
    input logic                        instr_rvalid_o,
    input logic                        data_req_i,
    input logic                        data_we_i,
    input logic                        data_gnt_o,
    input logic                        data_rvalid_o,
    input logic                        irq_o,
    input logic                        irq_ack_i,
    input logic [`MM_IRQ_ID_WIDTH-1:0] irq_id_i,
    input mm_region_e                  region_i
);

    timeunit 1ns;
    timeprecision 100ps;

    int   assert_errors = 0;
    logic timer_ack;

    assign timer_ack = irq_ack_i && (irq_id_i == `MM_IRQ_ID_WIDTH'(`MM_TIMER_IRQ_ID));

    // ------------------------------------------------------------------
    // grant and response timing
    data_gnt_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        data_gnt_o == data_req_i)
    else begin
        $error("data grant differs from data request");
        assert_errors++;
    end

    data_rvalid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        data_rvalid_o == $past(data_req_i && data_gnt_o))
    else begin
        $error("data rvalid does not follow the granted cycle");
        assert_errors++;
    end

    instr_rvalid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        instr_rvalid_o == $past(instr_req_i && instr_gnt_o))
    else begin
        $error("instruction rvalid does not follow the granted cycle");
        assert_errors++;
    end

    // ------------------------------------------------------------------
    // interrupt and address map
    irq_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (irq_o && !timer_ack) |=> irq_o)
    else begin
        $error("irq dropped without an acknowledge");
        assert_errors++;
    end

    no_unmapped_wr_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(data_req_i && data_we_i && region_i == REG_NONE))
    else begin
        $error("data write to an unmapped address");
        assert_errors++;
    end

endmodule

bind mm_ram_top mm_ram_chk mm_ram_chk_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .instr_req_i    (instr_req_i),
    .instr_gnt_o    (instr_gnt_o),
    .instr_rvalid_o (instr_rvalid_o),
    .data_req_i     (data_req_i),
    .data_we_i      (data_we_i),
    .data_gnt_o     (data_gnt_o),
    .data_rvalid_o  (data_rvalid_o),
    .irq_o          (irq_o),
    .irq_ack_i      (irq_ack_i),
    .irq_id_i       (irq_id_i),
    .region_i       (region)
);

// File: sim/mm_ram_tb.sv
// testbench for the simulation memory block
// replays the cases file and checks RAM, status, timer and debug behavior

`include "mm_ram_cfg.svh"

module mm_ram_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam time         CLK_PERIOD = 100ns;
    localparam logic [31:0] FILL_BASE  = 32'h0000_8000;

    logic                        clk_i;
    logic                        rst_ni;
    logic                        instr_req_i;
    logic [31:0]                 instr_addr_i;
    logic                        instr_gnt_o;
    logic                        instr_rvalid_o;
    logic [`MM_INSTR_WIDTH-1:0]  instr_rdata_o;
    logic                        data_req_i;
    logic [31:0]                 data_addr_i;
    logic                        data_we_i;
    logic [`MM_BE_WIDTH-1:0]     data_be_i;
    logic [`MM_DATA_WIDTH-1:0]   data_wdata_i;
    logic                        data_gnt_o;
    logic                        data_rvalid_o;
    logic [`MM_DATA_WIDTH-1:0]   data_rdata_o;
    logic                        irq_ack_i;
    logic [`MM_IRQ_ID_WIDTH-1:0] irq_id_i;
    logic                        irq_o;
    logic                        debug_req_o;
    logic                        tests_passed_o;
    logic                        tests_failed_o;
    logic                        exit_valid_o;
    logic [`MM_DATA_WIDTH-1:0]   exit_value_o;

    // one entry per case line
    byte          op_q   [$];
    string        name_q [$];
    logic [31:0]  addr_q [$];
    logic [31:0]  data_q [$];
    logic [127:0] exp_q  [$];
    // random words written between cases
    logic [31:0]  fill_q [$];

    // level that debug_req_o holds between debug cases
    logic dbg_level;

    int n_cases = 0;
    int errors  = 0;

    mm_ram_top mm_ram_top_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic report_mismatch(input string name, input logic [127:0] exp,
                                   input logic [127:0] act);
        errors++;
        $display("MISMATCH %s: expected %0h, actual %0h", name, exp, act);
    endtask

    task automatic report_failure(input string name, input string what);
        errors++;
        $display("ERROR %s: %s", name, what);
    endtask

    task automatic load_cases();
        int           fd;
        string        line;
        string        nm;
        byte          op;
        logic [31:0]  a;
        logic [31:0]  d;
        logic [127:0] x;
        fd = $fopen("sim/mm_ram_cases.txt", "r");
        if (fd == 0) begin
            report_failure("setup", "cannot open sim/mm_ram_cases.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") continue;
            if ($sscanf(line, "%c %s %h %h %h", op, nm, a, d, x) == 5) begin
                op_q.push_back(op);
                name_q.push_back(nm);
                addr_q.push_back(a);
                data_q.push_back(d);
                exp_q.push_back(x);
            end
        end
        $fclose(fd);
    endtask

    // one data bus access followed by an idle cycle
    task automatic data_access(input string name, input logic we, input logic [31:0] addr,
                               input logic [3:0] be, input logic [31:0] wdata,
                               output logic [31:0] rdata);
        @(posedge clk_i);
        data_req_i   <= 1'b1;
        data_we_i    <= we;
        data_addr_i  <= addr;
        data_be_i    <= be;
        data_wdata_i <= wdata;
        @(negedge clk_i);
        if (data_gnt_o !== 1'b1) report_failure(name, "data request not granted");
        if (data_rvalid_o !== 1'b0) report_failure(name, "data rvalid in the grant cycle");
        @(posedge clk_i);
        data_req_i <= 1'b0;
        data_we_i  <= 1'b0;
        @(negedge clk_i);
        if (data_rvalid_o !== 1'b1) report_failure(name, "no data rvalid after the grant");
        rdata = data_rdata_o;
    endtask

    task automatic fetch_line(input string name, input logic [31:0] addr,
                              input logic [127:0] exp);
        @(posedge clk_i);
        instr_req_i  <= 1'b1;
        instr_addr_i <= addr;
        @(negedge clk_i);
        if (instr_gnt_o !== 1'b1) report_failure(name, "fetch not granted");
        @(posedge clk_i);
        instr_req_i <= 1'b0;
        @(negedge clk_i);
        if (instr_rvalid_o !== 1'b1) report_failure(name, "no fetch rvalid after the grant");
        if (instr_rdata_o !== exp) report_mismatch(name, exp, instr_rdata_o);
    endtask

    // flags are {exit_valid, tests_failed, tests_passed}
    task automatic status_write(input string name, input logic [31:0] addr,
                                input logic [31:0] data, input logic [2:0] exp);
        logic [31:0] rd;
        logic [2:0]  flags;
        data_access(name, 1'b1, addr, 4'hF, data, rd);
        flags = {exit_valid_o, tests_failed_o, tests_passed_o};
        if (flags !== exp) report_mismatch(name, exp, flags);
        if (exp[2] && exit_value_o !== data) report_mismatch(name, data, exit_value_o);
        @(negedge clk_i);
        flags = {exit_valid_o, tests_failed_o, tests_passed_o};
        if (flags !== 3'b000) report_failure(name, "status pulse longer than one cycle");
    endtask

    task automatic timer_run(input string name, input logic [31:0] mask,
                             input logic [31:0] count, input logic [31:0] exp_cycles);
        logic [31:0] rd;
        int          n;
        logic        rose;
        data_access(name, 1'b1, `MM_TIMER_MASK_ADDR, 4'hF, mask, rd);
        data_access(name, 1'b1, `MM_TIMER_CNT_ADDR, 4'hF, count, rd);
        n    = 0;
        rose = 1'b0;
        // now just after the load edge
        while (!rose && n < int'(count) + 4) begin
            @(negedge clk_i);
            n++;
            rose = irq_o;
        end
        if (exp_cycles == 0) begin
            if (rose) report_failure(name, "irq rose with the timer masked");
        end else if (!rose) begin
            report_failure(name, "timer irq never rose");
        end else begin
            if (n != exp_cycles) report_mismatch(name, exp_cycles, n);
            // an acknowledge with another id leaves the irq alone
            @(posedge clk_i);
            irq_ack_i <= 1'b1;
            irq_id_i  <= 6'd5;
            @(posedge clk_i);
            irq_ack_i <= 1'b0;
            @(negedge clk_i);
            if (irq_o !== 1'b1) report_failure(name, "irq cleared by an ack with the wrong id");
            @(posedge clk_i);
            irq_ack_i <= 1'b1;
            irq_id_i  <= `MM_IRQ_ID_WIDTH'(`MM_TIMER_IRQ_ID);
            @(posedge clk_i);
            irq_ack_i <= 1'b0;
            @(negedge clk_i);
            if (irq_o !== 1'b0) report_failure(name, "irq not cleared by the timer ack");
        end
    endtask

    // timing word is {L, D} where an L of zero means level mode
    task automatic debug_run(input string name, input logic [31:0] ctrl,
                             input logic [31:0] timing);
        int   d;
        int   l;
        logic exp_lvl;
        d = int'(timing[15:0]);
        l = int'(timing[31:16]);
        @(posedge clk_i);
        data_req_i   <= 1'b1;
        data_we_i    <= 1'b1;
        data_addr_i  <= `MM_DEBUG_ADDR;
        data_be_i    <= 4'hF;
        data_wdata_i <= ctrl;
        // second write lands while the generator is busy
        @(posedge clk_i);
        data_wdata_i <= ctrl ^ 32'h8000_0000;
        @(posedge clk_i);
        data_req_i <= 1'b0;
        data_we_i  <= 1'b0;
        for (int n = 1; n <= d + l + 2; n++) begin
            @(negedge clk_i);
            if (n < d) begin
                exp_lvl = dbg_level;
            end else if (l == 0 || n < d + l) begin
                exp_lvl = ctrl[31];
            end else begin
                exp_lvl = !ctrl[31];
            end
            if (debug_req_o !== exp_lvl) begin
                report_mismatch($sformatf("%s cycle %0d", name, n), exp_lvl, debug_req_o);
            end
        end
        if (l == 0) begin
            dbg_level = ctrl[31];
        end else begin
            dbg_level = !ctrl[31];
        end
    endtask

    initial begin
        wait (n_cases > 0);
        #(CLK_PERIOD * n_cases * 200);
        $display("ERROR watchdog: run did not finish within %0d cycles", n_cases * 200);
        $display("Checks failed");
        $finish;
    end

    initial begin
        int unsigned seed;
        logic [31:0] rd;
        logic [31:0] word;
        int          chk_errors;
        seed         = $urandom(2729);
        rst_ni       = 1'b0;
        instr_req_i  = 1'b0;
        instr_addr_i = '0;
        data_req_i   = 1'b0;
        data_addr_i  = '0;
        data_we_i    = 1'b0;
        data_be_i    = '0;
        data_wdata_i = '0;
        irq_ack_i    = 1'b0;
        irq_id_i     = '0;
        dbg_level    = 1'b0;

        load_cases();
        n_cases = op_q.size();
        if (n_cases == 0) report_failure("setup", "no cases were read");

        repeat (8) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        if ({data_rvalid_o, instr_rvalid_o, irq_o, debug_req_o, tests_passed_o,
             tests_failed_o, exit_valid_o} !== 7'b0) begin
            report_failure("reset", "outputs not cleared after reset");
        end

        // ----------------------------------------------------------------------
        // replay the cases with a random RAM word written before each
        for (int i = 0; i < n_cases; i++) begin
            word = $urandom();
            data_access("fill", 1'b1, FILL_BASE + 32'(4 * i), 4'hF, word, rd);
            fill_q.push_back(word);
            case (op_q[i])
                "W": begin
                    data_access(name_q[i], 1'b1, addr_q[i], exp_q[i][3:0], data_q[i], rd);
                    if (rd !== 32'h0) report_mismatch(name_q[i], 32'h0, rd);
                end
                "R": begin
                    data_access(name_q[i], 1'b0, addr_q[i], 4'hF, 32'h0, rd);
                    if (rd !== exp_q[i][31:0]) report_mismatch(name_q[i], exp_q[i][31:0], rd);
                end
                "F": fetch_line(name_q[i], addr_q[i], exp_q[i]);
                "S": status_write(name_q[i], addr_q[i], data_q[i], exp_q[i][2:0]);
                "T": timer_run(name_q[i], addr_q[i], data_q[i], exp_q[i][31:0]);
                "D": debug_run(name_q[i], data_q[i], exp_q[i][31:0]);
                default: report_failure(name_q[i], "unknown operation code");
            endcase
        end

        // random words must have survived all later traffic
        for (int i = 0; i < fill_q.size(); i++) begin
            data_access($sformatf("fill_%0d", i), 1'b0, FILL_BASE + 32'(4 * i), 4'hF,
                        32'h0, rd);
            if (rd !== fill_q[i]) report_mismatch($sformatf("fill_%0d", i), fill_q[i], rd);
        end

        repeat (2) @(negedge clk_i);
        chk_errors = mm_ram_top_i.mm_ram_chk_i.assert_errors;
        errors += chk_errors;
        $display("cases: %0d, errors: %0d, assertion failures: %0d", n_cases, errors,
                 chk_errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: src/data_bus_ctrl.sv
// data bus response logic
// same-cycle grant, rvalid one cycle later, read data select

`include "mm_ram_cfg.svh"

module data_bus_ctrl
    import mm_ram_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      data_req_i,
    input  logic                      data_we_i,
    input  mm_region_e                region_i,
    input  logic [`MM_DATA_WIDTH-1:0] ram_rdata_i,
    output logic                      data_gnt_o,
    output logic                      data_rvalid_o,
    output logic [`MM_DATA_WIDTH-1:0] data_rdata_o
);

    logic       rvalid_q;
    logic       we_q;
    mm_region_e region_q;

    // every region answers at once
    assign data_gnt_o = data_req_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rvalid_q <= 1'b0;
            we_q     <= 1'b0;
            region_q <= REG_NONE;
        end else begin
            rvalid_q <= data_req_i;
            // remember where the access went, for the response cycle
            if (data_req_i) begin
                we_q     <= data_we_i;
                region_q <= region_i;
            end
        end
    end

    assign data_rvalid_o = rvalid_q;

    // ------------------------------------------------------------------
    // response data
    // only the RAM is readable, anything else returns the error word
    always_comb begin
        if (we_q) begin
            data_rdata_o = '0;
        end else if (region_q == REG_RAM) begin
            data_rdata_o = ram_rdata_i;
        end else begin
            data_rdata_o = `MM_ERR_RDATA;
        end
    end

endmodule

// File: src/debug_req_gen.sv
// debug request generator
// drives a level or pulse on debug_req_o after a programmed delay

`include "mm_ram_cfg.svh"

module debug_req_gen
    import mm_ram_pkg::*;
(
    input  logic          clk_i,
    input  logic          rst_ni,
    input  logic          debug_we_i,
    input  mm_data_word_u wdata_i,
    output logic          debug_req_o
);

    logic [14:0] start_cnt_q;
    logic [12:0] dur_cnt_q;
    logic        value_q;
    logic        idle;

    // a new request is only taken once both counters have run out
    assign idle = (start_cnt_q == '0) && (dur_cnt_q == '0);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            start_cnt_q <= '0;
            dur_cnt_q   <= '0;
            value_q     <= 1'b0;
            debug_req_o <= 1'b0;
        end else if (debug_we_i && idle) begin
            // a zero delay or duration behaves as one cycle
            if (wdata_i.dbg.delay == '0) begin
                start_cnt_q <= 15'd1;
            end else begin
                start_cnt_q <= wdata_i.dbg.delay;
            end

            value_q <= wdata_i.dbg.value;

            // level mode leaves the duration at zero
            if (!wdata_i.dbg.pulse) begin
                dur_cnt_q <= '0;
            end else if (wdata_i.dbg.duration == '0) begin
                dur_cnt_q <= 13'd1;
            end else begin
                dur_cnt_q <= wdata_i.dbg.duration;
            end
        end else begin
            // ----------------------------------------------------------
            // delay phase, then the pulse phase
            if (start_cnt_q != '0) begin
                start_cnt_q <= start_cnt_q - 1'b1;
                if (start_cnt_q == 15'd1) begin
                    debug_req_o <= value_q;
                end
            end else if (dur_cnt_q != '0) begin
                dur_cnt_q <= dur_cnt_q - 1'b1;
                if (dur_cnt_q == 13'd1) begin
                    debug_req_o <= !value_q;
                end
            end
        end
    end

endmodule

// File: src/dp_ram.sv
// dual-port byte RAM
// port A reads aligned instruction lines, port B does word data accesses

`include "mm_ram_cfg.svh"

module dp_ram #(
    parameter int ADDR_WIDTH  = `MM_RAM_ADDR_WIDTH,
    parameter int INSTR_WIDTH = `MM_INSTR_WIDTH,
    parameter int DATA_WIDTH  = `MM_DATA_WIDTH
) (
    input  logic                    clk_i,
    input  logic                    rst_ni,

    // port A, instruction fetch
    input  logic                    a_req_i,
    input  logic [ADDR_WIDTH-1:0]   a_addr_i,
    output logic [INSTR_WIDTH-1:0]  a_rdata_o,
    output logic                    a_rvalid_o,

    // port B, data access
    input  logic                    b_req_i,
    input  logic                    b_we_i,
    input  logic [DATA_WIDTH/8-1:0] b_be_i,
    input  logic [ADDR_WIDTH-1:0]   b_addr_i,
    input  logic [DATA_WIDTH-1:0]   b_wdata_i,
    output logic [DATA_WIDTH-1:0]   b_rdata_o
);

    localparam int A_BYTES = INSTR_WIDTH / 8;
    localparam int B_BYTES = DATA_WIDTH / 8;
    localparam int A_LSB   = $clog2(A_BYTES);
    localparam int B_LSB   = $clog2(B_BYTES);

    logic [7:0]            mem [0:2**ADDR_WIDTH-1];
    logic [ADDR_WIDTH-1:0] a_base;
    logic [ADDR_WIDTH-1:0] b_base;

    assign a_base = {a_addr_i[ADDR_WIDTH-1:A_LSB], {A_LSB{1'b0}}};
    assign b_base = {b_addr_i[ADDR_WIDTH-1:B_LSB], {B_LSB{1'b0}}};

    // instruction line, byte 0 in the low lane
    always_ff @(posedge clk_i) begin
        if (a_req_i) begin
            for (int i = 0; i < A_BYTES; i++) begin
                a_rdata_o[8*i +: 8] <= mem[a_base + ADDR_WIDTH'(i)];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            a_rvalid_o <= 1'b0;
        end else begin
            a_rvalid_o <= a_req_i;
        end
    end

    // data word, write under byte enables or read back
    always_ff @(posedge clk_i) begin
        if (b_req_i) begin
            for (int i = 0; i < B_BYTES; i++) begin
                if (b_we_i && b_be_i[i]) begin
                    mem[b_base + ADDR_WIDTH'(i)] <= b_wdata_i[8*i +: 8];
                end
                b_rdata_o[8*i +: 8] <= mem[b_base + ADDR_WIDTH'(i)];
            end
        end
    end

endmodule

// File: src/mm_addr_decode.sv
// data address decoder
// picks the target region and raises one qualified request or write strobe

`include "mm_ram_cfg.svh"

module mm_addr_decode
    import mm_ram_pkg::*;
(
    input  logic        data_req_i,
    input  logic        data_we_i,
    input  logic [31:0] data_addr_i,
    output mm_region_e  region_o,
    output logic        ram_req_o,
    output logic        status_we_o,
    output logic        exit_we_o,
    output logic        timer_mask_we_o,
    output logic        timer_cnt_we_o,
    output logic        debug_we_o
);

    localparam logic [31:0] RAM_SIZE = 32'd1 << `MM_RAM_ADDR_WIDTH;

    logic wr;

    // RAM sits at the bottom of the map, registers are single words
    always_comb begin
        if (data_addr_i < RAM_SIZE) begin
            region_o = REG_RAM;
        end else if (data_addr_i == `MM_STATUS_ADDR) begin
            region_o = REG_STATUS;
        end else if (data_addr_i == `MM_EXIT_ADDR) begin
            region_o = REG_EXIT;
        end else if (data_addr_i == `MM_TIMER_MASK_ADDR) begin
            region_o = REG_TIMER_MASK;
        end else if (data_addr_i == `MM_TIMER_CNT_ADDR) begin
            region_o = REG_TIMER_CNT;
        end else if (data_addr_i == `MM_DEBUG_ADDR) begin
            region_o = REG_DEBUG;
        end else begin
            region_o = REG_NONE;
        end
    end

    assign wr = data_req_i && data_we_i;

    // RAM takes reads and writes, the registers are write only
    assign ram_req_o       = data_req_i && (region_o == REG_RAM);
    assign status_we_o     = wr && (region_o == REG_STATUS);
    assign exit_we_o       = wr && (region_o == REG_EXIT);
    assign timer_mask_we_o = wr && (region_o == REG_TIMER_MASK);
    assign timer_cnt_we_o  = wr && (region_o == REG_TIMER_CNT);
    assign debug_we_o      = wr && (region_o == REG_DEBUG);

endmodule

// File: src/mm_ram_cfg.svh
// memory map and sizing constants for the simulation memory block
// shared by the RTL and the testbench

`ifndef MM_RAM_CFG_SVH
`define MM_RAM_CFG_SVH

// ----------------------------------------------------------------------
// bus and memory widths
`define MM_RAM_ADDR_WIDTH   16
`define MM_INSTR_WIDTH      128
`define MM_DATA_WIDTH       32
`define MM_BE_WIDTH         (`MM_DATA_WIDTH / 8)
`define MM_IRQ_ID_WIDTH     6

// ----------------------------------------------------------------------
// pseudo peripheral register addresses
`define MM_STATUS_ADDR      32'h2000_0000
`define MM_EXIT_ADDR        32'h2000_0004
`define MM_TIMER_MASK_ADDR  32'h1500_0000
`define MM_TIMER_CNT_ADDR   32'h1500_0004
`define MM_DEBUG_ADDR       32'h1500_0008

// ----------------------------------------------------------------------
// magic values
`define MM_PASS_MAGIC       32'd123456789
`define MM_FAIL_MAGIC       32'd1
// timer irq id, doubles as the enable bit in the mask register
`define MM_TIMER_IRQ_ID     3
`define MM_ERR_RDATA        32'hBADC_0DE0

`endif

// File: src/mm_ram_pkg.sv
// types shared by the memory block: decoded data region and the
// write data word with its debug control field view

`include "mm_ram_cfg.svh"

package mm_ram_pkg;

    // target of a data access, one per mapped location
    typedef enum logic [2:0] {
        REG_RAM,
        REG_STATUS,
        REG_EXIT,
        REG_TIMER_MASK,
        REG_TIMER_CNT,
        REG_DEBUG,
        REG_NONE
    } mm_region_e;

    // debug control word layout
    // bits 29 and 15 were random options and are not used
    typedef struct packed {
        logic        value;
        logic        pulse;
        logic        rsvd_29;
        logic [12:0] duration;
        logic        rsvd_15;
        logic [14:0] delay;
    } mm_debug_ctrl_t;

    typedef union packed {
        logic [`MM_DATA_WIDTH-1:0] raw;
        mm_debug_ctrl_t            dbg;
    } mm_data_word_u;

endpackage

// File: src/mm_ram_top.sv
// memory and pseudo peripheral block for a small RISC-V core
// instruction and data ports into a shared RAM, plus status, timer and debug

`include "mm_ram_cfg.svh"

module mm_ram_top
    import mm_ram_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        rst_ni,

    // instruction bus
    input  logic                        instr_req_i,
    input  logic [31:0]                 instr_addr_i,
    output logic                        instr_gnt_o,
    output logic                        instr_rvalid_o,
    output logic [`MM_INSTR_WIDTH-1:0]  instr_rdata_o,

    // data bus
    input  logic                        data_req_i,
    input  logic [31:0]                 data_addr_i,
    input  logic                        data_we_i,
    input  logic [`MM_BE_WIDTH-1:0]     data_be_i,
    input  logic [`MM_DATA_WIDTH-1:0]   data_wdata_i,
    output logic                        data_gnt_o,
    output logic                        data_rvalid_o,
    output logic [`MM_DATA_WIDTH-1:0]   data_rdata_o,

    // interrupts
    input  logic                        irq_ack_i,
    input  logic [`MM_IRQ_ID_WIDTH-1:0] irq_id_i,
    output logic                        irq_o,

    output logic                        debug_req_o,

    // test status
    output logic                        tests_passed_o,
    output logic                        tests_failed_o,
    output logic                        exit_valid_o,
    output logic [`MM_DATA_WIDTH-1:0]   exit_value_o
);

    mm_region_e                 region;
    logic                       ram_req;
    logic                       status_we;
    logic                       exit_we;
    logic                       timer_mask_we;
    logic                       timer_cnt_we;
    logic                       debug_we;
    logic [`MM_DATA_WIDTH-1:0]  ram_rdata;
    mm_data_word_u              wdata_word;

    assign wdata_word.raw = data_wdata_i;

    // the RAM always accepts a fetch
    assign instr_gnt_o = instr_req_i;

    // ------------------------------------------------------------------
    // data path decode and response
    mm_addr_decode mm_addr_decode_i (
        .data_req_i      (data_req_i),
        .data_we_i       (data_we_i),
        .data_addr_i     (data_addr_i),
        .region_o        (region),
        .ram_req_o       (ram_req),
        .status_we_o     (status_we),
        .exit_we_o       (exit_we),
        .timer_mask_we_o (timer_mask_we),
        .timer_cnt_we_o  (timer_cnt_we),
        .debug_we_o      (debug_we)
    );

    data_bus_ctrl data_bus_ctrl_i (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .data_req_i    (data_req_i),
        .data_we_i     (data_we_i),
        .region_i      (region),
        .ram_rdata_i   (ram_rdata),
        .data_gnt_o    (data_gnt_o),
        .data_rvalid_o (data_rvalid_o),
        .data_rdata_o  (data_rdata_o)
    );

    // ------------------------------------------------------------------
    // shared RAM
    dp_ram #(
        .ADDR_WIDTH  (`MM_RAM_ADDR_WIDTH),
        .INSTR_WIDTH (`MM_INSTR_WIDTH),
        .DATA_WIDTH  (`MM_DATA_WIDTH)
    ) dp_ram_i (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .a_req_i    (instr_req_i),
        .a_addr_i   (instr_addr_i[`MM_RAM_ADDR_WIDTH-1:0]),
        .a_rdata_o  (instr_rdata_o),
        .a_rvalid_o (instr_rvalid_o),
        .b_req_i    (ram_req),
        .b_we_i     (data_we_i),
        .b_be_i     (data_be_i),
        .b_addr_i   (data_addr_i[`MM_RAM_ADDR_WIDTH-1:0]),
        .b_wdata_i  (data_wdata_i),
        .b_rdata_o  (ram_rdata)
    );

    // ------------------------------------------------------------------
    // pseudo peripherals
    sim_periph sim_periph_i (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .wdata_i         (wdata_word.raw),
        .status_we_i     (status_we),
        .exit_we_i       (exit_we),
        .timer_mask_we_i (timer_mask_we),
        .timer_cnt_we_i  (timer_cnt_we),
        .irq_ack_i       (irq_ack_i),
        .irq_id_i        (irq_id_i),
        .tests_passed_o  (tests_passed_o),
        .tests_failed_o  (tests_failed_o),
        .exit_valid_o    (exit_valid_o),
        .exit_value_o    (exit_value_o),
        .irq_o           (irq_o)
    );

    debug_req_gen debug_req_gen_i (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .debug_we_i  (debug_we),
        .wdata_i     (wdata_word),
        .debug_req_o (debug_req_o)
    );

endmodule

// File: src/sim_periph.sv
// test status, exit and timer registers
// one-cycle status pulses and a countdown timer with a masked interrupt

`include "mm_ram_cfg.svh"

module sim_periph (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic [`MM_DATA_WIDTH-1:0]   wdata_i,
    input  logic                        status_we_i,
    input  logic                        exit_we_i,
    input  logic                        timer_mask_we_i,
    input  logic                        timer_cnt_we_i,
    input  logic                        irq_ack_i,
    input  logic [`MM_IRQ_ID_WIDTH-1:0] irq_id_i,
    output logic                        tests_passed_o,
    output logic                        tests_failed_o,
    output logic                        exit_valid_o,
    output logic [`MM_DATA_WIDTH-1:0]   exit_value_o,
    output logic                        irq_o
);

    logic                      timer_en_q;
    logic [`MM_DATA_WIDTH-1:0] timer_cnt_q;
    logic                      timer_ack;

    // ------------------------------------------------------------------
    // status and exit pulses, one cycle after the write
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tests_passed_o <= 1'b0;
            tests_failed_o <= 1'b0;
            exit_valid_o   <= 1'b0;
        end else begin
            tests_passed_o <= status_we_i && (wdata_i == `MM_PASS_MAGIC);
            tests_failed_o <= status_we_i && (wdata_i == `MM_FAIL_MAGIC);
            exit_valid_o   <= exit_we_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (exit_we_i) begin
            exit_value_o <= wdata_i;
        end
    end

    // ------------------------------------------------------------------
    // timer
    // counts down while the timer registers are left alone; irq fires on 1 -> 0
    assign timer_ack = irq_ack_i && (irq_id_i == `MM_IRQ_ID_WIDTH'(`MM_TIMER_IRQ_ID));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            timer_en_q  <= 1'b0;
            timer_cnt_q <= '0;
            irq_o       <= 1'b0;
        end else begin
            if (timer_mask_we_i) begin
                timer_en_q <= wdata_i[`MM_TIMER_IRQ_ID];
            end

            if (timer_cnt_we_i) begin
                timer_cnt_q <= wdata_i;
            end else if (!timer_mask_we_i && timer_cnt_q != '0) begin
                timer_cnt_q <= timer_cnt_q - 1'b1;
            end

            // an acknowledge wins over a new expiry in the same cycle
            if (timer_ack) begin
                irq_o <= 1'b0;
            end else if (!timer_mask_we_i && !timer_cnt_we_i &&
                         timer_cnt_q == `MM_DATA_WIDTH'(1) && timer_en_q) begin
                irq_o <= 1'b1;
            end
        end
    end

endmodule
